// File: Bender.yml
package:
  name: d2d_adapter

sources:
  - include_dirs:
      - src
    files:
      - src/d2d_pkg.sv
      - src/d2d_flit_framer.sv
      - src/d2d_retry_buffer.sv
      - src/d2d_phy_tx.sv
      - src/d2d_link_monitor.sv
      - src/d2d_adapter_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_d2d_adapter.sv

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: sim/tb_d2d_adapter.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module tb_d2d_adapter
    import d2d_pkg::*;
();

    localparam int DEPTH = `D2D_RETRY_DEPTH;
    localparam int MSG_W = `D2D_PROTO_W + `D2D_FLIT_W;

    logic        clk;
    logic        rst_n;
    flit_data_t  protocol_tx_flit;
    proto_id_t   protocol_tx_proto;
    logic        protocol_tx_valid;
    logic        protocol_tx_ready;
    phy_frame_t  phy_tx_flit;
    logic        phy_tx_valid;
    logic        phy_tx_ready;
    logic        retry_request;
    logic        ack_valid;
    seq_num_t    ack_seq;
    logic        link_trained;
    logic        training_complete;
    logic        link_up;
    logic [1:0]  debug_select;
    debug_word_t debug_status;

    // Reference model of every accepted frame in acceptance order
    phy_frame_t  model_q[$];
    int          expect_idx;
    int          ack_idx;
    int          phy_count;
    int          retry_pulses;

    // Stimulus state copied onto the DUT inputs at each falling edge
    flit_data_t  pend_flit;
    proto_id_t   pend_proto;
    logic        pend_valid;
    logic        input_on;
    logic        ack_on;
    logic        ready_random;
    logic        trained_lvl;
    logic        complete_lvl;
    logic [1:0]  dbg_sel;
    logic [31:0] lfsr_state;

    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    d2d_adapter_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .protocol_tx_flit  (protocol_tx_flit),
        .protocol_tx_proto (protocol_tx_proto),
        .protocol_tx_valid (protocol_tx_valid),
        .protocol_tx_ready (protocol_tx_ready),
        .phy_tx_flit       (phy_tx_flit),
        .phy_tx_valid      (phy_tx_valid),
        .phy_tx_ready      (phy_tx_ready),
        .retry_request     (retry_request),
        .ack_valid         (ack_valid),
        .ack_seq           (ack_seq),
        .link_trained      (link_trained),
        .training_complete (training_complete),
        .link_up           (link_up),
        .debug_select      (debug_select),
        .debug_status      (debug_status)
    );

    // ======================================================================
    // Random source and model helpers
    // ======================================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Id then data MSB first with the register preset to all ones
    function automatic crc_t ref_crc(input proto_id_t p, input flit_data_t d);
        logic [MSG_W-1:0] bits;
        crc_t             r;
        logic             b;
        bits = {p, d};
        r    = {`D2D_CRC_W{1'b1}};
        for (int j = 0; j < MSG_W; j++) begin
            b = bits[MSG_W-1-j] ^ r[`D2D_CRC_W-1];
            r = (r << 1) ^ (b ? crc_t'(`D2D_CRC_POLY) : crc_t'(0));
        end
        return r;
    endfunction

    function automatic phy_frame_t model_frame(input int idx, input proto_id_t p,
                                               input flit_data_t d);
        return {seq_num_t'(idx), p, d, ref_crc(p, d)};
    endfunction

    // ======================================================================
    // Checks and reporting
    // ======================================================================

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic report_timeout(input string msg);
        $display("timeout: %s", msg);
        test_errors++;
    endtask

    task automatic compare_frame(input phy_frame_t got, input phy_frame_t exp,
                                 input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic compare_count(input stat_count_t got, input stat_count_t exp,
                                 input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ======================================================================
    // One clock cycle of stimulus and model update
    // ======================================================================

    task automatic run_cycle(input logic do_retry, input logic ack_all);
        int   span;
        int   ack_target;
        logic want_new;
        @(negedge clk);
        want_new = (rand_bits(1) != 0);
        if (!pend_valid && want_new) begin
            pend_flit  = rand_bits(`D2D_FLIT_W);
            pend_proto = proto_id_t'(rand_bits(`D2D_PROTO_W));
            pend_valid = 1'b1;
        end
        protocol_tx_flit  = pend_flit;
        protocol_tx_proto = pend_proto;
        protocol_tx_valid = input_on && pend_valid && (rand_bits(1) != 0);
        phy_tx_ready      = ready_random ? (rand_bits(1) != 0) : 1'b1;
        retry_request     = do_retry;
        link_trained      = trained_lvl;
        training_complete = complete_lvl;
        debug_select      = dbg_sel;

        // Acknowledge only frames that went out in the current pass
        span       = expect_idx - ack_idx;
        ack_target = -1;
        if (span > 0 && (ack_all || (ack_on && rand_bits(3) == 0))) begin
            ack_target = ack_all ? expect_idx - 1 : ack_idx + int'(rand_bits(8)) % span;
        end
        ack_valid = (ack_target >= 0);
        ack_seq   = ack_valid ? seq_num_t'(ack_target) : '0;

        // Predict the handshakes of the coming edge from settled outputs
        #1;
        if (phy_tx_valid && phy_tx_ready) begin
            phy_count++;
            if (expect_idx >= model_q.size()) begin
                report_error("phy sent a frame beyond the last accepted flit");
            end else begin
                compare_frame(phy_tx_flit, model_q[expect_idx], "phy frame");
            end
            expect_idx++;
            if (expect_idx - ack_idx > DEPTH) begin
                report_error("more unacknowledged frames on the phy than buffer entries");
            end
        end
        if (protocol_tx_valid && protocol_tx_ready) begin
            model_q.push_back(model_frame(model_q.size(), pend_proto, pend_flit));
            pend_valid = 1'b0;
        end
        if (ack_valid) begin
            ack_idx = ack_target + 1;
        end
        if (do_retry) begin
            expect_idx = ack_idx;
            retry_pulses++;
        end
    endtask

    task automatic wait_link(input logic level, input string what);
        int n;
        n = 0;
        while (link_up !== level && n < 50) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (link_up !== level) begin
            report_timeout($sformatf("link_up did not %s", what));
        end
    endtask

    task automatic drain_phy(input int limit);
        int n;
        n        = 0;
        input_on = 1'b0;
        while ((expect_idx < model_q.size() || phy_tx_valid) && n < limit) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (expect_idx < model_q.size() || phy_tx_valid) begin
            report_timeout($sformatf("phy did not send every accepted frame in %0d cycles",
                                     limit));
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin : main
        int n;
        int low_run;

        protocol_tx_flit  = '0;
        protocol_tx_proto = '0;
        protocol_tx_valid = 1'b0;
        phy_tx_ready      = 1'b0;
        retry_request     = 1'b0;
        ack_valid         = 1'b0;
        ack_seq           = '0;
        link_trained      = 1'b0;
        training_complete = 1'b0;
        debug_select      = 2'd0;
        lfsr_state        = 32'h3d197a7c;
        pend_flit         = '0;
        pend_proto        = '0;
        pend_valid        = 1'b0;
        input_on          = 1'b0;
        ack_on            = 1'b0;
        ready_random      = 1'b1;
        trained_lvl       = 1'b0;
        complete_lvl      = 1'b0;
        dbg_sel           = 2'd0;
        expect_idx        = 0;
        ack_idx           = 0;
        phy_count         = 0;
        retry_pulses      = 0;
        test_errors       = 0;
        total_errors      = 0;
        tests_run         = 0;
        tests_failed      = 0;

        n = 0;
        while (rst_n !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset was never released");
        end

        // Bring-up with flits offered while the link is down
        input_on = 1'b1;
        repeat (4) begin
            run_cycle(1'b0, 1'b0);
            compare_bit(link_up, 1'b0, "link_up before training");
            compare_bit(protocol_tx_ready, 1'b0, "protocol_tx_ready before training");
            compare_bit(phy_tx_valid, 1'b0, "phy_tx_valid after reset");
        end
        trained_lvl = 1'b1;
        repeat (4) begin
            run_cycle(1'b0, 1'b0);
            compare_bit(link_up, 1'b0, "link_up while training");
            compare_bit(protocol_tx_ready, 1'b0, "protocol_tx_ready while training");
        end
        input_on     = 1'b0;
        complete_lvl = 1'b1;
        wait_link(1'b1, "rise after training");
        dbg_sel = 2'd0;
        run_cycle(1'b0, 1'b0);
        run_cycle(1'b0, 1'b0);
        compare_count(stat_count_t'(debug_status[31:16]), stat_count_t'(link_active),
                      "debug state code");
        if (debug_status[15:0] == '0) begin
            report_error("uptime reads zero while the link is active");
        end
        trained_lvl = 1'b0;
        wait_link(1'b0, "fall after link_trained dropped");
        trained_lvl = 1'b1;
        wait_link(1'b1, "rise again");
        finish_test("bring-up");

        // Framing under random traffic and back-pressure
        input_on     = 1'b1;
        ack_on       = 1'b1;
        ready_random = 1'b1;
        repeat (300) run_cycle(1'b0, 1'b0);
        drain_phy(400);
        repeat (4) begin
            run_cycle(1'b0, 1'b0);
            compare_bit(phy_tx_valid, 1'b0, "phy_tx_valid once drained");
        end
        if (model_q.size() < 20) begin
            report_error("too few flits accepted during random traffic");
        end
        run_cycle(1'b0, 1'b1);
        finish_test("framing");

        // Buffer limit with nothing acknowledged
        ack_on   = 1'b0;
        input_on = 1'b1;
        low_run  = 0;
        n        = 0;
        while (low_run < 32 && n < 600) begin
            run_cycle(1'b0, 1'b0);
            low_run = protocol_tx_ready ? 0 : low_run + 1;
            n++;
        end
        if (low_run < 32) begin
            report_timeout("protocol_tx_ready never stayed low with no acknowledges");
        end
        ready_random = 1'b0;
        repeat (20) begin
            run_cycle(1'b0, 1'b0);
            compare_bit(protocol_tx_ready, 1'b0, "protocol_tx_ready with buffer full");
        end
        compare_count(stat_count_t'(expect_idx - ack_idx), stat_count_t'(DEPTH),
                      "unacknowledged frames sent");
        if (model_q.size() - ack_idx > DEPTH + 1) begin
            report_error("more flits accepted than the buffer and framer can hold");
        end
        finish_test("buffer limit");

        // Acknowledge reopens the input
        ready_random = 1'b1;
        run_cycle(1'b0, 1'b1);
        n = 0;
        while (!protocol_tx_ready && n < 20) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (!protocol_tx_ready) begin
            report_timeout("input did not resume after the acknowledge");
        end
        ack_on = 1'b1;
        repeat (200) run_cycle(1'b0, 1'b0);
        drain_phy(400);
        run_cycle(1'b0, 1'b1);
        finish_test("acknowledge");

        // Replay once mid-stream and once when idle
        ack_on   = 1'b0;
        input_on = 1'b1;
        repeat (12) run_cycle(1'b0, 1'b0);
        run_cycle(1'b1, 1'b0);
        repeat (20) run_cycle(1'b0, 1'b0);
        input_on = 1'b0;
        repeat (3) run_cycle(1'b0, 1'b0);
        if (expect_idx == ack_idx) begin
            report_error("no unacknowledged frames left to replay");
        end
        run_cycle(1'b1, 1'b0);
        drain_phy(400);
        dbg_sel = 2'd1;
        run_cycle(1'b0, 1'b0);
        compare_count(stat_count_t'(debug_status), stat_count_t'(phy_count), "tx_count");
        dbg_sel = 2'd2;
        run_cycle(1'b0, 1'b0);
        compare_count(stat_count_t'(debug_status), stat_count_t'(retry_pulses), "retry_count");
        run_cycle(1'b0, 1'b1);
        finish_test("replay");

        $display("%0d tests run, %0d failing, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/d2d_pkg.sv
src/d2d_flit_framer.sv
src/d2d_retry_buffer.sv
src/d2d_phy_tx.sv
src/d2d_link_monitor.sv
src/d2d_adapter_top.sv
sim/tb_clock_gen.sv
sim/tb_d2d_adapter.sv

// File: src/d2d_adapter_top.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module d2d_adapter_top
    import d2d_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // Protocol layer
    input  flit_data_t  protocol_tx_flit,
    input  proto_id_t   protocol_tx_proto,
    input  logic        protocol_tx_valid,
    output logic        protocol_tx_ready,

    // Phy layer
    output phy_frame_t  phy_tx_flit,
    output logic        phy_tx_valid,
    input  logic        phy_tx_ready,

    // Far side retry and ack pulses
    input  logic        retry_request,
    input  logic        ack_valid,
    input  seq_num_t    ack_seq,

    // Link status and debug
    input  logic        link_trained,
    input  logic        training_complete,
    output logic        link_up,
    input  logic [1:0]  debug_select,
    output debug_word_t debug_status
);

    phy_frame_t  frame;
    logic        frame_valid;
    logic        frame_ready;
    phy_frame_t  head_frame;
    logic        head_valid;
    logic        head_take;
    stat_count_t tx_count;
    stat_count_t retry_count;

    // ======================================================================
    // Transmit path
    // ======================================================================

    d2d_flit_framer u_framer (
        .clk               (clk),
        .rst_n             (rst_n),
        .protocol_tx_flit  (protocol_tx_flit),
        .protocol_tx_proto (protocol_tx_proto),
        .protocol_tx_valid (protocol_tx_valid),
        .link_up           (link_up),
        .protocol_tx_ready (protocol_tx_ready),
        .frame             (frame),
        .frame_valid       (frame_valid),
        .frame_ready       (frame_ready)
    );

    d2d_retry_buffer u_retry_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .frame_ready   (frame_ready),
        .head_frame    (head_frame),
        .head_valid    (head_valid),
        .head_take     (head_take),
        .retry_request (retry_request),
        .ack_valid     (ack_valid),
        .ack_seq       (ack_seq)
    );

    d2d_phy_tx u_phy_tx (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_frame    (head_frame),
        .head_valid    (head_valid),
        .head_take     (head_take),
        .retry_request (retry_request),
        .phy_tx_flit   (phy_tx_flit),
        .phy_tx_valid  (phy_tx_valid),
        .phy_tx_ready  (phy_tx_ready),
        .tx_count      (tx_count),
        .retry_count   (retry_count)
    );

    // ======================================================================
    // Link control and status
    // ======================================================================

    d2d_link_monitor u_link_monitor (
        .clk               (clk),
        .rst_n             (rst_n),
        .link_trained      (link_trained),
        .training_complete (training_complete),
        .link_up           (link_up),
        .tx_count          (tx_count),
        .retry_count       (retry_count),
        .debug_select      (debug_select),
        .debug_status      (debug_status)
    );

endmodule

// File: src/d2d_flit_framer.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module d2d_flit_framer
    import d2d_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  flit_data_t protocol_tx_flit,
    input  proto_id_t  protocol_tx_proto,
    input  logic       protocol_tx_valid,
    input  logic       link_up,
    output logic       protocol_tx_ready,
    output phy_frame_t frame,
    output logic       frame_valid,
    input  logic       frame_ready
);

    seq_num_t next_seq;
    logic     accept;

    // CRC over {proto, data}, MSB first, seed all ones, no reflection
    function automatic crc_t crc_calc(input proto_id_t proto, input flit_data_t data);
        logic [`D2D_PROTO_W+`D2D_FLIT_W-1:0] msg;
        crc_t                                crc;
        logic                                fb;
        msg = {proto, data};
        crc = '1;
        for (int i = `D2D_PROTO_W + `D2D_FLIT_W - 1; i >= 0; i--) begin
            fb  = crc[`D2D_CRC_W-1] ^ msg[i];
            crc = {crc[`D2D_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ `D2D_CRC_POLY;
            end
        end
        return crc;
    endfunction

    // Slot free, or emptied by the buffer this cycle
    assign protocol_tx_ready = link_up && (!frame_valid || frame_ready);
    assign accept            = protocol_tx_valid && protocol_tx_ready;

    // ======================================================================
    // Output slot control and sequence counter
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
            next_seq    <= '0;
        end else begin
            if (accept) begin
                frame_valid <= 1'b1;
                next_seq    <= next_seq + 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= {next_seq, protocol_tx_proto, protocol_tx_flit,
                      crc_calc(protocol_tx_proto, protocol_tx_flit)};
        end
    end

endmodule

// File: src/d2d_link_monitor.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module d2d_link_monitor
    import d2d_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        link_trained,
    input  logic        training_complete,
    output logic        link_up,
    input  stat_count_t tx_count,
    input  stat_count_t retry_count,
    input  logic [1:0]  debug_select,
    output debug_word_t debug_status
);

    link_state_t state;
    link_state_t state_nxt;
    stat_count_t uptime;

    // ======================================================================
    // Link state machine
    // ======================================================================

    always_comb begin
        state_nxt = state;
        if (!link_trained) begin
            state_nxt = link_reset;
        end else begin
            case (state)
                link_reset:    state_nxt = link_training;
                link_training: if (training_complete) state_nxt = link_active;
                link_active:   state_nxt = link_active;
                default:       state_nxt = link_reset;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= link_reset;
            link_up <= 1'b0;
        end else begin
            state   <= state_nxt;
            link_up <= (state_nxt == link_active);
        end
    end

    // Uptime in active only, held at max
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uptime <= '0;
        end else if (state != link_active) begin
            uptime <= '0;
        end else if (uptime != '1) begin
            uptime <= uptime + 1'b1;
        end
    end

    // ======================================================================
    // Debug readout
    // ======================================================================

    always_comb begin
        case (debug_select)
            2'd0:    debug_status = {16'(state), 16'(uptime)};
            2'd1:    debug_status = debug_word_t'(tx_count);
            2'd2:    debug_status = debug_word_t'(retry_count);
            default: debug_status = '0;
        endcase
    end

endmodule

// File: src/d2d_params.svh
`ifndef D2D_PARAMS_SVH
`define D2D_PARAMS_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================

// Protocol flit payload
`define D2D_FLIT_W 32
// Protocol id carried alongside each flit
`define D2D_PROTO_W 4
// Frame sequence number, wraps
`define D2D_SEQ_W 8
`define D2D_CRC_W 32

// ==========================================================================
// Link layer constants
// ==========================================================================

// CRC-32, normal form
`define D2D_CRC_POLY 32'h04C11DB7
// Power of two, no more than 2**D2D_SEQ_W
`define D2D_RETRY_DEPTH 16
`define D2D_STAT_W 16

`endif

// File: src/d2d_phy_tx.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module d2d_phy_tx
    import d2d_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  phy_frame_t  head_frame,
    input  logic        head_valid,
    output logic        head_take,
    input  logic        retry_request,
    output phy_frame_t  phy_tx_flit,
    output logic        phy_tx_valid,
    input  logic        phy_tx_ready,
    output stat_count_t tx_count,
    output stat_count_t retry_count
);

    logic sent;

    assign sent = phy_tx_valid && phy_tx_ready;

    // Refill when empty or draining, never in the retry cycle
    assign head_take = head_valid && (!phy_tx_valid || phy_tx_ready) && !retry_request;

    // ======================================================================
    // Output register
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phy_tx_valid <= 1'b0;
        end else if (retry_request) begin
            // Flush so replay begins at the oldest frame
            phy_tx_valid <= 1'b0;
        end else if (head_take) begin
            phy_tx_valid <= 1'b1;
        end else if (phy_tx_ready) begin
            phy_tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (head_take) begin
            phy_tx_flit <= head_frame;
        end
    end

    // ======================================================================
    // Statistics
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_count    <= '0;
            retry_count <= '0;
        end else begin
            if (sent && (tx_count != '1)) begin
                tx_count <= tx_count + 1'b1;
            end
            if (retry_request && (retry_count != '1)) begin
                retry_count <= retry_count + 1'b1;
            end
        end
    end

endmodule

// File: src/d2d_pkg.sv
`include "d2d_params.svh"

package d2d_pkg;

    // ======================================================================
    // Payload and frame types
    // ======================================================================

    typedef logic [`D2D_FLIT_W-1:0]  flit_data_t;
    typedef logic [`D2D_PROTO_W-1:0] proto_id_t;
    typedef logic [`D2D_SEQ_W-1:0]   seq_num_t;
    typedef logic [`D2D_CRC_W-1:0]   crc_t;

    // MSB first: seq, proto id, data, crc
    typedef logic [`D2D_SEQ_W+`D2D_PROTO_W+`D2D_FLIT_W+`D2D_CRC_W-1:0] phy_frame_t;

    // ======================================================================
    // Status and debug types
    // ======================================================================

    // Saturating counter
    typedef logic [`D2D_STAT_W-1:0] stat_count_t;
    typedef logic [31:0]            debug_word_t;

    // Link states, codes visible on the debug readout
    typedef enum logic [1:0] {
        link_reset    = 2'd0,
        link_training = 2'd1,
        link_active   = 2'd2
    } link_state_t;

endpackage

// File: src/d2d_retry_buffer.sv
`timescale 1ns/1ps
`include "d2d_params.svh"

module d2d_retry_buffer
    import d2d_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  phy_frame_t frame,
    input  logic       frame_valid,
    output logic       frame_ready,
    output phy_frame_t head_frame,
    output logic       head_valid,
    input  logic       head_take,
    input  logic       retry_request,
    input  logic       ack_valid,
    input  seq_num_t   ack_seq
);

    localparam int IDX_W   = $clog2(`D2D_RETRY_DEPTH);
    localparam int PTR_W   = IDX_W + 1;
    localparam int SEQ_MSB = $bits(phy_frame_t) - 1;

    phy_frame_t       mem [`D2D_RETRY_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] send_ptr;
    logic [PTR_W-1:0] ack_ptr;
    logic [PTR_W-1:0] ack_ptr_nxt;
    logic [PTR_W-1:0] send_ptr_nxt;
    logic [PTR_W-1:0] stored_cnt;
    logic [PTR_W-1:0] send_dist;
    logic [PTR_W-1:0] ack_dist;
    seq_num_t         oldest_seq;
    seq_num_t         ack_ofs;

    // Unacknowledged frames held, full at depth
    assign stored_cnt  = wr_ptr - ack_ptr;
    assign frame_ready = (stored_cnt != PTR_W'(`D2D_RETRY_DEPTH));

    assign head_valid = (send_ptr != wr_ptr);
    assign head_frame = mem[send_ptr[IDX_W-1:0]];

    assign oldest_seq = mem[ack_ptr[IDX_W-1:0]][SEQ_MSB -: `D2D_SEQ_W];
    assign ack_ofs    = ack_seq - oldest_seq;

    // ======================================================================
    // Pointer update
    // ======================================================================

    always_comb begin
        ack_ptr_nxt = ack_ptr;
        // Offset past the oldest entry tells how far the ack reaches
        if (ack_valid && (ack_ofs < seq_num_t'(stored_cnt))) begin
            ack_ptr_nxt = ack_ptr + PTR_W'(ack_ofs) + 1'b1;
        end

        send_ptr_nxt = send_ptr;
        if (head_take) begin
            send_ptr_nxt = send_ptr + 1'b1;
        end

        send_dist = send_ptr_nxt - ack_ptr;
        ack_dist  = ack_ptr_nxt - ack_ptr;

        if (retry_request) begin
            send_ptr_nxt = ack_ptr_nxt;
        end else if (send_dist < ack_dist) begin
            // Ack overtook a rewound send pointer
            send_ptr_nxt = ack_ptr_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            send_ptr <= '0;
            ack_ptr  <= '0;
        end else begin
            if (frame_valid && frame_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            send_ptr <= send_ptr_nxt;
            ack_ptr  <= ack_ptr_nxt;
        end
    end

    // Frame storage
    always_ff @(posedge clk) begin
        if (frame_valid && frame_ready) begin
            mem[wr_ptr[IDX_W-1:0]] <= frame;
        end
    end

endmodule
